/* src/ex_defines.svh */
`ifndef EX_DEFINES_SVH
`define EX_DEFINES_SVH

// integer datapath width
`define EX_XLEN 32

// one data cache beat, two words
`define EX_DWORD 64

// rs2 bits that count as shift amount
`define EX_SHAMT_BITS 5

// rob / phys reg tag carried with a load
`define EX_TAG_BITS 6

// result on a func code with no operation behind it
// easy to spot in waves
`define EX_ALU_FILLER 32'hfacebeec

`endif

/* src/ex_pkg.sv */
`default_nettype none

`include "ex_defines.svh"

package ex_pkg;

    // alu function select, order follows the decode table
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_OR   = 4'd5,
        ALU_XOR  = 4'd6,
        ALU_SRL  = 4'd7,
        ALU_SLL  = 4'd8,
        ALU_SRA  = 4'd9
    } alu_func_e;

    // branch funct3 straight from the instruction
    // 3'd2 and 3'd3 have no meaning
    typedef enum logic [2:0] {
        BR_EQ  = 3'd0,
        BR_NE  = 3'd1,
        BR_LT  = 3'd4,
        BR_GE  = 3'd5,
        BR_LTU = 3'd6,
        BR_GEU = 3'd7
    } branch_func_e;

    // access size, low two bits of load funct3
    typedef enum logic [1:0] {
        MEM_BYTE = 2'd0,
        MEM_HALF = 2'd1,
        MEM_WORD = 2'd2
    } mem_size_e;

    // what the load unit needs out of the issue packet
    typedef struct packed {
        logic                      valid;
        logic                      rd_mem;
        // [1:0] size, [2] unsigned
        logic [2:0]                funct3;
        logic [`EX_TAG_BITS-1:0]   dest_tag;
    } ex_packet_t;

    // request towards the data cache
    typedef struct packed {
        logic                  en;
        logic [`EX_XLEN-1:0]   addr;
    } dcache_req_t;

    // one cycle answer from the data cache
    typedef struct packed {
        logic                  valid;
        logic [`EX_DWORD-1:0]  data;
    } dcache_resp_t;

endpackage

`default_nettype wire

/* src/int_alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ex_defines.svh"

// single cycle integer alu
// pure combinational, shared by the int path and load address generation
module int_alu
    import ex_pkg::*;
(
    input  wire logic [`EX_XLEN-1:0] opa,
    input  wire logic [`EX_XLEN-1:0] opb,
    input  wire alu_func_e           func,
    output logic [`EX_XLEN-1:0]      result
);

    // signed views for slt and sra
    logic signed [`EX_XLEN-1:0] signed_opa;
    logic signed [`EX_XLEN-1:0] signed_opb;
    // shift amount, upper opb bits ignored
    logic [`EX_SHAMT_BITS-1:0] shamt;
    // compare outcomes
    logic lt_signed;
    logic lt_unsigned;

    assign signed_opa = opa;
    assign signed_opb = opb;
    assign shamt      = opb[`EX_SHAMT_BITS-1:0];

    assign lt_signed   = signed_opa < signed_opb;
    assign lt_unsigned = opa < opb;

    always_comb begin
        case (func)
            ALU_ADD:  result = opa + opb;
            ALU_SUB:  result = opa - opb;
            ALU_AND:  result = opa & opb;
            // set-less-than gives 0 or 1 in bit 0
            ALU_SLT:  result = {{(`EX_XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU: result = {{(`EX_XLEN-1){1'b0}}, lt_unsigned};
            ALU_OR:   result = opa | opb;
            ALU_XOR:  result = opa ^ opb;
            ALU_SRL:  result = opa >> shamt;
            ALU_SLL:  result = opa << shamt;
            // arithmetic, sign bit shifted in
            ALU_SRA:  result = signed_opa >>> shamt;
            // codes 10..15
            default:  result = `EX_ALU_FILLER;
        endcase
    end

endmodule

`default_nettype wire

/* src/branch_cond.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ex_defines.svh"

// conditional branch resolve, combinational
module branch_cond
    import ex_pkg::*;
(
    input  wire logic [`EX_XLEN-1:0] rs1,
    input  wire logic [`EX_XLEN-1:0] rs2,
    input  wire branch_func_e        func,
    output logic                     take
);

    // signed copies for blt / bge
    logic signed [`EX_XLEN-1:0] signed_rs1;
    logic signed [`EX_XLEN-1:0] signed_rs2;

    assign signed_rs1 = rs1;
    assign signed_rs2 = rs2;

    always_comb begin
        case (func)
            BR_EQ:   take = rs1 == rs2;
            BR_NE:   take = rs1 != rs2;
            BR_LT:   take = signed_rs1 < signed_rs2;
            BR_GE:   take = signed_rs1 >= signed_rs2;
            // unsigned pair
            BR_LTU:  take = rs1 < rs2;
            BR_GEU:  take = rs1 >= rs2;
            // funct3 2 and 3, never taken
            default: take = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* src/load_align.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ex_defines.svh"

// picks the addressed word out of a cache beat
// then trims and extends it to the load size
module load_align
    import ex_pkg::*;
(
    input  wire logic [`EX_DWORD-1:0] dword,
    input  wire logic                 addr_word_sel,
    input  wire logic [2:0]           funct3,
    output logic [`EX_XLEN-1:0]       data
);

    mem_size_e             size;
    logic                  is_unsigned;
    logic [`EX_XLEN-1:0]   word;
    // fill bits for the upper part
    logic                  byte_fill;
    logic                  half_fill;

    assign size        = mem_size_e'(funct3[1:0]);
    assign is_unsigned = funct3[2];

    // addr bit 2 set means upper word of the beat
    assign word = addr_word_sel ? dword[`EX_DWORD-1:`EX_XLEN] : dword[`EX_XLEN-1:0];

    // lbu / lhu fill with zero, lb / lh copy the sign
    assign byte_fill = is_unsigned ? 1'b0 : word[7];
    assign half_fill = is_unsigned ? 1'b0 : word[15];

    always_comb begin
        case (size)
            MEM_BYTE: data = {{(`EX_XLEN-8){byte_fill}}, word[7:0]};
            MEM_HALF: data = {{(`EX_XLEN-16){half_fill}}, word[15:0]};
            // full word, signedness irrelevant
            default:  data = word;
        endcase
    end

endmodule

`default_nettype wire

/* src/load_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ex_defines.svh"

// load functional unit
// captures the load on start, holds it while the cache is busy,
// finishes combinationally in the cycle the cache answers
module load_unit
    import ex_pkg::*;
(
    input  wire logic                clock,
    input  wire logic                reset,
    input  wire logic                start,
    input  wire logic [`EX_XLEN-1:0] opa,
    input  wire logic [`EX_XLEN-1:0] opb,
    input  wire alu_func_e           func,
    input  wire ex_packet_t          packet,
    output dcache_req_t              dcache_req,
    input  wire dcache_resp_t        dcache_resp,
    output logic [`EX_XLEN-1:0]      result,
    output logic                     done,
    output ex_packet_t               packet_out
);

    // unit holds a load
    logic                  busy;
    // captured instruction, inputs may move after start
    logic [`EX_XLEN-1:0]   cur_opa;
    logic [`EX_XLEN-1:0]   cur_opb;
    alu_func_e             cur_func;
    ex_packet_t            cur_packet;
    // effective address and aligned data
    logic [`EX_XLEN-1:0]   addr;
    logic [`EX_XLEN-1:0]   aligned;

    // address generator on the held operands
    int_alu i_addr_alu (
        .opa    (cur_opa),
        .opb    (cur_opb),
        .func   (cur_func),
        .result (addr)
    );

    // word select and extension of the returned beat
    load_align i_load_align (
        .dword         (dcache_resp.data),
        .addr_word_sel (addr[2]),
        .funct3        (cur_packet.funct3),
        .data          (aligned)
    );

    // request held high for the whole wait
    // a packet without rd_mem never reaches the cache
    assign dcache_req.en   = busy & cur_packet.valid & cur_packet.rd_mem;
    assign dcache_req.addr = addr;

    // a response while idle is dropped here
    assign done   = busy & dcache_resp.valid;
    assign result = done ? aligned : '0;

    // nothing to show when idle
    assign packet_out = busy ? cur_packet : '0;

    // busy flag
    always_ff @(posedge clock) begin
        if (reset) begin
            busy <= 1'b0;
        end else if (start) begin
            busy <= 1'b1;
        end else if (done) begin
            // back to idle the edge after the response
            busy <= 1'b0;
        end
    end

    // operand and packet hold, only loaded on start
    always_ff @(posedge clock) begin
        if (start) begin
            cur_opa    <= opa;
            cur_opb    <= opb;
            cur_func   <= func;
            cur_packet <= packet;
        end
    end

endmodule

`default_nettype wire

/* src/ex_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ex_defines.svh"

// integer execute stage
// alu and branch resolve in the issue cycle, loads take a variable number
module ex_stage
    import ex_pkg::*;
(
    input  wire logic                clock,
    input  wire logic                reset,
    // operands shared by all units
    input  wire logic [`EX_XLEN-1:0] opa,
    input  wire logic [`EX_XLEN-1:0] opb,
    // alu issue
    input  wire alu_func_e           alu_func,
    input  wire logic                alu_en,
    // branch issue
    input  wire branch_func_e        branch_func,
    // load issue, one cycle pulse, only while idle
    input  wire logic                load_start,
    input  wire ex_packet_t          load_packet,
    // data cache side
    input  wire dcache_resp_t        dcache_resp,
    // alu result
    output logic [`EX_XLEN-1:0]      alu_result,
    output logic                     alu_done,
    // branch decision
    output logic                     take,
    output dcache_req_t              dcache_req,
    // load completion
    output logic [`EX_XLEN-1:0]      load_result,
    output logic                     load_done,
    output ex_packet_t               load_packet_out
);

    // alu finishes in the same cycle
    assign alu_done = alu_en;

    int_alu i_int_alu (
        .opa    (opa),
        .opb    (opb),
        .func   (alu_func),
        .result (alu_result)
    );

    // rs1 / rs2 are the same operand buses
    branch_cond i_branch_cond (
        .rs1  (opa),
        .rs2  (opb),
        .func (branch_func),
        .take (take)
    );

    // alu_func also selects the address op for the load
    load_unit i_load_unit (
        .clock       (clock),
        .reset       (reset),
        .start       (load_start),
        .opa         (opa),
        .opb         (opb),
        .func        (alu_func),
        .packet      (load_packet),
        .dcache_req  (dcache_req),
        .dcache_resp (dcache_resp),
        .result      (load_result),
        .done        (load_done),
        .packet_out  (load_packet_out)
    );

endmodule

`default_nettype wire

/* verification/ex_model.svh */
`ifndef EX_MODEL_SVH
`define EX_MODEL_SVH

// odd multiplier for the memory image
localparam logic [31:0] MEM_MULT = 32'h9e3779b1;

// expected alu output for one operation
function automatic logic [`EX_XLEN-1:0] alu_ref(input logic [3:0] func,
                                                input logic [`EX_XLEN-1:0] a,
                                                input logic [`EX_XLEN-1:0] b);
    logic [4:0] sh;
    sh = b[4:0];
    case (func)
        ALU_ADD:  return a + b;
        ALU_SUB:  return a - b;
        ALU_AND:  return a & b;
        ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
        ALU_OR:   return a | b;
        ALU_XOR:  return a ^ b;
        ALU_SRL:  return a >> sh;
        ALU_SLL:  return a << sh;
        ALU_SRA:  return $signed(a) >>> sh;
        default:  return `EX_ALU_FILLER;
    endcase
endfunction

// branch decision, codes 2 and 3 never taken
function automatic logic taken_ref(input logic [2:0] func,
                                   input logic [`EX_XLEN-1:0] a,
                                   input logic [`EX_XLEN-1:0] b);
    case (func)
        3'd0:    return a == b;
        3'd1:    return a != b;
        3'd4:    return $signed(a) < $signed(b);
        3'd5:    return $signed(a) >= $signed(b);
        3'd6:    return a < b;
        3'd7:    return a >= b;
        default: return 1'b0;
    endcase
endfunction

// memory beat as a function of the double word address
function automatic logic [`EX_DWORD-1:0] mem_image(input logic [`EX_XLEN-1:0] addr);
    logic [31:0] lo;
    lo = {3'b000, addr[31:3]} * MEM_MULT;
    // upper word is the complement
    return {~lo, lo};
endfunction

// word pick plus size and sign handling
function automatic logic [`EX_XLEN-1:0] extend_load(input logic [`EX_DWORD-1:0] dword,
                                                    input logic [`EX_XLEN-1:0] addr,
                                                    input logic [2:0] funct3);
    logic [31:0] word;
    word = addr[2] ? dword[63:32] : dword[31:0];
    case (funct3[1:0])
        2'd0:    return funct3[2] ? {24'd0, word[7:0]} : {{24{word[7]}}, word[7:0]};
        2'd1:    return funct3[2] ? {16'd0, word[15:0]} : {{16{word[15]}}, word[15:0]};
        default: return word;
    endcase
endfunction

`endif

/* verification/ex_stage_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ex_defines.svh"

module ex_stage_tb
    import ex_pkg::*;
();

    localparam int PERIOD       = 4;
    localparam int RESET_CYCLES = 3;
    localparam int N_ALU        = 300;
    localparam int N_BRANCH     = 200;
    localparam int N_LOADS      = 60;
    localparam int N_NOMEM      = 10;
    localparam int MAX_DELAY    = 5;
    // twice the worst case length of all tests
    localparam int WATCHDOG_NS  = ((N_LOADS + N_NOMEM) * (MAX_DELAY + 4) + N_ALU + N_BRANCH
                                   + RESET_CYCLES) * PERIOD * 2;

    logic                clock;
    logic                reset;
    logic [`EX_XLEN-1:0] opa;
    logic [`EX_XLEN-1:0] opb;
    alu_func_e           alu_func;
    logic                alu_en;
    branch_func_e        branch_func;
    logic                load_start;
    ex_packet_t          load_packet;
    dcache_resp_t        dcache_resp;
    logic [`EX_XLEN-1:0] alu_result;
    logic                alu_done;
    logic                take;
    dcache_req_t         dcache_req;
    logic [`EX_XLEN-1:0] load_result;
    logic                load_done;
    ex_packet_t          load_packet_out;

    integer seed = 32'h2b94cf46;
    int     checks = 0;
    int     errors = 0;
    // set by a load start to wake the responder
    logic   resp_pending = 1'b0;

    `include "ex_model.svh"

    ex_stage i_dut (
        .clock           (clock),
        .reset           (reset),
        .opa             (opa),
        .opb             (opb),
        .alu_func        (alu_func),
        .alu_en          (alu_en),
        .branch_func     (branch_func),
        .load_start      (load_start),
        .load_packet     (load_packet),
        .dcache_resp     (dcache_resp),
        .alu_result      (alu_result),
        .alu_done        (alu_done),
        .take            (take),
        .dcache_req      (dcache_req),
        .load_result     (load_result),
        .load_done       (load_done),
        .load_packet_out (load_packet_out)
    );

    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic report_test(input string name, input int items, input int mark);
        $display("test %s: %0d items, %0d errors", name, items, errors - mark);
    endtask

    // one load from start pulse to idle again
    task automatic run_load(input logic with_mem);
        ex_packet_t          pkt;
        logic [31:0]         r;
        logic [`EX_XLEN-1:0] a;
        logic [`EX_XLEN-1:0] b;
        logic [`EX_XLEN-1:0] addr;
        int                  waited;
        logic                finished;
        r = $random(seed);
        pkt.valid = with_mem ? 1'b1 : r[0];
        pkt.rd_mem = with_mem;
        pkt.funct3[2] = r[8];
        pkt.funct3[1:0] = r[7:0] % 8'd3;
        pkt.dest_tag = r[21:16];
        a = $random(seed);
        b = $random(seed);
        addr = a + b;
        @(negedge clock);
        load_start = 1'b1;
        opa = a;
        opb = b;
        alu_func = ALU_ADD;
        load_packet = pkt;
        @(negedge clock);
        // inputs move on while the unit works from its own copy
        load_start = 1'b0;
        opa = $random(seed);
        opb = $random(seed);
        load_packet = '0;
        resp_pending = 1'b1;
        finished = 1'b0;
        waited = 0;
        while (!finished) begin
            #1;
            check_value("load_en", pkt.valid & pkt.rd_mem, dcache_req.en);
            if (pkt.valid & pkt.rd_mem) begin
                check_value("load_addr", addr, dcache_req.addr);
            end
            check_value("load_packet", pkt, load_packet_out);
            if (load_done) begin
                check_value("load_data", extend_load(mem_image(addr), addr, pkt.funct3),
                            load_result);
                finished = 1'b1;
            end else begin
                waited++;
                if (waited > MAX_DELAY) begin
                    errors++;
                    $display("load_done never came, gave up after %0d cycles", waited);
                    finished = 1'b1;
                end
            end
            @(negedge clock);
        end
        // unit is idle one cycle after done
        #1;
        check_value("load_en_clear", 0, dcache_req.en);
        check_value("load_packet_clear", 0, load_packet_out);
        check_value("load_done_clear", 0, load_done);
    endtask

    // cache answers each load once after 0 to 5 cycles
    initial begin : cache_responder
        int          delay;
        logic [31:0] r;
        forever begin
            wait (resp_pending);
            resp_pending = 1'b0;
            r = $random(seed);
            delay = r[7:0] % 8'd6;
            repeat (delay) @(negedge clock);
            dcache_resp.valid = 1'b1;
            dcache_resp.data = mem_image(dcache_req.addr);
            @(negedge clock);
            dcache_resp = '0;
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout: tests still running after %0d ns", WATCHDOG_NS);
        $display("sim failed");
        $finish;
    end

    initial begin : main
        int          mark;
        logic [31:0] r;
        logic [3:0]  code;
        reset = 1'b1;
        opa = '0;
        opb = '0;
        alu_func = ALU_ADD;
        alu_en = 1'b0;
        branch_func = BR_EQ;
        load_start = 1'b0;
        load_packet = '0;
        dcache_resp = '0;
        repeat (RESET_CYCLES) @(negedge clock);
        reset = 1'b0;
        // stray response while idle must not complete anything
        dcache_resp.valid = 1'b1;
        dcache_resp.data = mem_image('0);
        #1;
        mark = errors;
        check_value("reset_en", 0, dcache_req.en);
        check_value("reset_done", 0, load_done);
        check_value("reset_result", 0, load_result);
        check_value("reset_packet", 0, load_packet_out);
        report_test("reset_state", 4, mark);
        @(negedge clock);
        dcache_resp = '0;

        mark = errors;
        for (int i = 0; i < N_ALU; i++) begin
            @(negedge clock);
            r = $random(seed);
            code = r[7:0] % 8'd10;
            alu_func = alu_func_e'(code);
            alu_en = r[8];
            opa = $random(seed);
            opb = $random(seed);
            // equal operands now and then for the compares
            if (r[11:9] == 3'd0) begin
                opb = opa;
            end
            #1;
            check_value("alu_result", alu_ref(code, opa, opb), alu_result);
            check_value("alu_done", alu_en, alu_done);
        end
        alu_en = 1'b0;
        report_test("alu_ops", N_ALU, mark);

        mark = errors;
        for (int i = 0; i < N_BRANCH; i++) begin
            @(negedge clock);
            r = $random(seed);
            // all eight codes including the illegal 2 and 3
            branch_func = branch_func_e'(r[2:0]);
            opa = $random(seed);
            opb = $random(seed);
            if (r[5:3] == 3'd0) begin
                opb = opa;
            end
            #1;
            check_value("branch_take", taken_ref(r[2:0], opa, opb), take);
        end
        report_test("branch_cond", N_BRANCH, mark);

        mark = errors;
        for (int i = 0; i < N_LOADS; i++) begin
            run_load(1'b1);
        end
        report_test("load_data", N_LOADS, mark);

        mark = errors;
        for (int i = 0; i < N_NOMEM; i++) begin
            run_load(1'b0);
        end
        report_test("load_no_mem", N_NOMEM, mark);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* ex_stage.f */
+incdir+src
+incdir+verification
src/ex_pkg.sv
src/int_alu.sv
src/branch_cond.sv
src/load_align.sv
src/load_unit.sv
src/ex_stage.sv
verification/ex_stage_tb.sv

/* Bender.yml */
package:
  name: ex_stage

sources:
  - include_dirs:
      - src
    files:
      - src/ex_pkg.sv
      - src/int_alu.sv
      - src/branch_cond.sv
      - src/load_align.sv
      - src/load_unit.sv
      - src/ex_stage.sv
  - target: test
    include_dirs:
      - src
      - verification
    files:
      - verification/ex_stage_tb.sv
